/* dcache_if.sv */
`timescale 1ns/10ps

interface dcache_req_if;
    import dcache_pkg::*;

    mem_op_e              op;
    logic                 uncache;
    logic [TAG_W-1:0]     tag;
    logic [INDEX_W-1:0]   index;
    logic [1:0]           word_off;
    // also the way number for index-invalidate
    logic [1:0]           byte_off;
    access_size_e         size;
    logic [3:0]           strb;
    logic [31:0]          wdata;
    logic                 cacop;
    cacop_code_e          cacop_code;

    modport decode (
        output op, uncache, tag, index, word_off, byte_off, size, strb, wdata,
        output cacop, cacop_code
    );
    modport fsm (input op, uncache, word_off, byte_off, strb, cacop, cacop_code);
    modport ways (input tag, index, word_off, wdata);
    modport refill (input uncache, word_off);
endinterface

interface way_ctrl_if;
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0]     way_visit;
    logic [NUM_WAYS-1:0]     mem_en;
    logic [LINE_WORDS*4-1:0] mem_we;
    logic [NUM_WAYS-1:0]     tagv_we;
    logic                    tagv_clear;
    logic                    fill_en;
    logic [NUM_WAYS-1:0]     hit;
    logic                    cache_hit;
    logic [NUM_WAYS-1:0]     lru_way_sel;

    modport fsm (
        output way_visit, mem_en, mem_we, tagv_we, tagv_clear, fill_en,
        input hit, cache_hit, lru_way_sel
    );
    modport ways (
        input way_visit, mem_en, mem_we, tagv_we, tagv_clear, fill_en,
        output hit, cache_hit, lru_way_sel
    );
endinterface

/* dcache_main_fsm.sv */
`timescale 1ns/10ps

module dcache_main_fsm (
    input  logic          clk,
    input  logic          rstn,
    input  logic          valid,
    input  logic          cacop_en,
    input  logic          r_rdy,
    input  logic          r_valid,
    input  logic          r_last,
    input  logic          w_rdy,
    input  logic          w_done,
    dcache_req_if.fsm     req,
    way_ctrl_if.fsm       ctrl,
    output logic          rbuf_we,
    output logic          cache_ready,
    output logic          data_valid,
    output logic          cacop_complete,
    output logic          r_req,
    output logic [7:0]    r_length,
    output logic          w_req
);
    import dcache_pkg::*;

    cache_state_e state, state_nxt;
    logic [LINE_WORDS*4-1:0] hit_we_mask;
    logic                    accept;

    // store strobe placed at its word in the line
    assign hit_we_mask = {{(LINE_WORDS*4-4){1'b0}}, req.strb} << {req.word_off, 2'b00};
    assign accept      = valid || cacop_en;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, EXTRA_READY: begin
                if (cacop_en) begin
                    state_nxt = CACOP_COPE;
                end else if (valid) begin
                    state_nxt = LOOKUP;
                end else begin
                    state_nxt = IDLE;
                end
            end
            LOOKUP: begin
                if (req.op == WRITE) begin
                    state_nxt = MISS;
                end else if (req.uncache || !ctrl.cache_hit) begin
                    state_nxt = REPLACE;
                end else if (cacop_en) begin
                    state_nxt = CACOP_COPE;
                end else if (valid) begin
                    state_nxt = LOOKUP;
                end else begin
                    state_nxt = IDLE;
                end
            end
            MISS: begin
                if (w_rdy) state_nxt = WAIT_WRITE;
            end
            WAIT_WRITE: begin
                if (w_done) state_nxt = EXTRA_READY;
            end
            REPLACE: begin
                if (r_rdy) state_nxt = REFILL;
            end
            REFILL: begin
                if (r_valid && r_last) state_nxt = EXTRA_READY;
            end
            CACOP_COPE: state_nxt = EXTRA_READY;
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        rbuf_we          = 1'b0;
        cache_ready      = 1'b0;
        data_valid       = 1'b0;
        cacop_complete   = 1'b0;
        r_req            = 1'b0;
        r_length         = 8'(LINE_BURST_LEN);
        w_req            = 1'b0;
        ctrl.way_visit   = '0;
        ctrl.mem_en      = '0;
        ctrl.mem_we      = '0;
        ctrl.tagv_we     = '0;
        ctrl.tagv_clear  = 1'b0;
        ctrl.fill_en     = 1'b0;
        case (state)
            IDLE: begin
                cache_ready = 1'b1;
                rbuf_we     = accept;
            end
            LOOKUP: begin
                if (req.op == WRITE) begin
                    // write-through, update the hit way only
                    if (!req.uncache && ctrl.cache_hit) begin
                        ctrl.way_visit = ctrl.hit;
                        ctrl.mem_en    = ctrl.hit;
                        ctrl.mem_we    = hit_we_mask;
                    end
                end else if (!req.uncache && ctrl.cache_hit) begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                    rbuf_we     = accept;
                end
            end
            MISS: w_req = 1'b1;
            REPLACE: begin
                r_req = 1'b1;
                if (req.uncache) r_length = 8'd0;
            end
            REFILL: begin
                if (r_valid && r_last && !req.uncache) begin
                    ctrl.fill_en   = 1'b1;
                    ctrl.way_visit = ctrl.lru_way_sel;
                    ctrl.mem_en    = ctrl.lru_way_sel;
                    ctrl.mem_we    = '1;
                    ctrl.tagv_we   = ctrl.lru_way_sel;
                end
            end
            CACOP_COPE: begin
                ctrl.tagv_clear = 1'b1;
                if (req.cacop_code == INDEX_INVALIDATE) begin
                    ctrl.tagv_we = NUM_WAYS'(1) << req.byte_off;
                end else begin
                    ctrl.tagv_we = ctrl.hit;
                end
            end
            EXTRA_READY: begin
                data_valid     = 1'b1;
                cacop_complete = req.cacop;
                cache_ready    = 1'b1;
                rbuf_we        = accept;
            end
            default: ;
        endcase
    end

    // a fill only ever installs a line that missed
    a_fill_on_miss: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.fill_en |-> !ctrl.cache_hit);

    a_one_bus_req: assert property (@(posedge clk) disable iff (!rstn)
        !(r_req && w_req));

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    // fsm states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL,
        WAIT_WRITE,
        CACOP_COPE,
        EXTRA_READY
    } cache_state_e;

    typedef enum logic {
        READ,
        WRITE
    } mem_op_e;

    // same code as the memory bus size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic {
        INDEX_INVALIDATE,
        HIT_INVALIDATE
    } cacop_code_e;

    // geometry
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int LINE_WORDS     = 4;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = 24;
    localparam int OFFSET_W       = 4;
    // beats minus one for a full line
    localparam int LINE_BURST_LEN = 3;

endpackage

/* dcache_refill.sv */
`timescale 1ns/10ps

module dcache_refill (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     r_valid,
    input  logic [31:0]                              r_data,
    input  logic [dcache_pkg::LINE_WORDS*32-1:0]     line_data,
    dcache_req_if.refill                             req,
    output logic [dcache_pkg::LINE_WORDS*32-1:0]     fill_line,
    output logic [31:0]                              rdata
);
    import dcache_pkg::*;

    localparam int CNT_W = $clog2(LINE_WORDS);

    logic [LINE_WORDS-1:0][31:0] line_buf;
    logic [CNT_W-1:0]            beat_cnt;
    logic                        just_filled;
    logic                        last_beat;

    // a line takes four beats, an uncached read one
    assign last_beat = req.uncache || (beat_cnt == CNT_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt    <= '0;
            just_filled <= 1'b0;
        end else begin
            just_filled <= r_valid && last_beat;
            if (r_valid) beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid) line_buf[beat_cnt] <= r_data;
    end

    // last beat goes straight into the line written this cycle
    always_comb begin
        fill_line = line_buf;
        if (r_valid) fill_line[beat_cnt*32 +: 32] = r_data;
    end

    // uncached beat sits in word 0, a refilled line is read at the word offset
    always_comb begin
        if (just_filled) begin
            rdata = req.uncache ? line_buf[0] : line_buf[req.word_off];
        end else begin
            rdata = line_data[req.word_off*32 +: 32];
        end
    end

endmodule

/* dcache_req_decode.sv */
`timescale 1ns/10ps

module dcache_req_decode (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       valid,
    input  dcache_pkg::mem_op_e        op,
    input  logic                       uncache,
    input  logic [31:0]                addr,
    input  dcache_pkg::access_size_e   size,
    input  logic [31:0]                wdata,
    input  logic                       cacop_en,
    input  dcache_pkg::cacop_code_e    cacop_code,
    input  logic                       rbuf_we,
    dcache_req_if.decode               req
);
    import dcache_pkg::*;

    logic [3:0]  strb_dec;
    logic [31:0] wdata_lane;

    always_comb begin
        case (size)
            SIZE_BYTE: strb_dec = 4'b0001 << addr[1:0];
            SIZE_HALF: strb_dec = 4'b0011 << {addr[1], 1'b0};
            default:   strb_dec = 4'b1111;
        endcase
    end

    // core gives narrow data in the low bits
    assign wdata_lane = wdata << {addr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.cacop <= 1'b0;
            req.op    <= READ;
        end else if (rbuf_we) begin
            req.cacop <= cacop_en;
            req.op    <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            req.uncache    <= uncache;
            req.tag        <= addr[31:INDEX_W+OFFSET_W];
            req.index      <= addr[INDEX_W+OFFSET_W-1:OFFSET_W];
            req.word_off   <= addr[OFFSET_W-1:2];
            req.byte_off   <= addr[1:0];
            req.size       <= size;
            req.strb       <= strb_dec;
            req.wdata      <= wdata_lane;
            req.cacop_code <= cacop_code;
        end
    end

    // natural alignment of a normal access, seen in the stored request
    a_aligned: assert property (@(posedge clk) disable iff (!rstn)
        rbuf_we && valid && !cacop_en |=>
            (req.size != SIZE_HALF || !req.byte_off[0]) &&
            (req.size != SIZE_WORD || req.byte_off == 2'b00));

endmodule

/* dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       valid,
    input  dcache_pkg::mem_op_e        op,
    input  logic                       uncache,
    input  logic [31:0]                addr,
    input  dcache_pkg::access_size_e   size,
    input  logic [31:0]                wdata,
    input  logic                       cacop_en,
    input  dcache_pkg::cacop_code_e    cacop_code,
    output logic                       cache_ready,
    output logic                       data_valid,
    output logic [31:0]                rdata,
    output logic                       cacop_complete,
    output logic                       r_req,
    output logic [31:0]                r_addr,
    output logic [7:0]                 r_length,
    input  logic                       r_rdy,
    input  logic                       r_valid,
    input  logic                       r_last,
    input  logic [31:0]                r_data,
    output logic                       w_req,
    output logic [31:0]                w_addr,
    output logic [31:0]                w_data,
    output logic [3:0]                 w_strb,
    input  logic                       w_rdy,
    input  logic                       w_done
);
    import dcache_pkg::*;

    logic                     rbuf_we;
    logic [LINE_WORDS*32-1:0] fill_line;
    logic [LINE_WORDS*32-1:0] line_data;

    dcache_req_if req_if ();
    way_ctrl_if   ctrl_if ();

    dcache_req_decode i_req_decode (
        .clk, .rstn, .valid, .op, .uncache, .addr, .size, .wdata,
        .cacop_en, .cacop_code, .rbuf_we, .req(req_if.decode)
    );

    dcache_main_fsm i_main_fsm (
        .clk, .rstn, .valid, .cacop_en, .r_rdy, .r_valid, .r_last, .w_rdy, .w_done,
        .req(req_if.fsm), .ctrl(ctrl_if.fsm), .rbuf_we, .cache_ready, .data_valid,
        .cacop_complete, .r_req, .r_length, .w_req
    );

    dcache_ways i_ways (
        .clk, .rstn, .fill_line, .req(req_if.ways), .ctrl(ctrl_if.ways), .line_data
    );

    dcache_refill i_refill (
        .clk, .rstn, .r_valid, .r_data, .line_data, .req(req_if.refill),
        .fill_line, .rdata
    );

    // cached reads fetch the whole line
    assign r_addr = req_if.uncache ?
        {req_if.tag, req_if.index, req_if.word_off, req_if.byte_off} :
        {req_if.tag, req_if.index, {OFFSET_W{1'b0}}};
    assign w_addr = {req_if.tag, req_if.index, req_if.word_off, req_if.byte_off};
    assign w_data = req_if.wdata;
    assign w_strb = req_if.strb;

endmodule

/* dcache_ways.sv */
`timescale 1ns/10ps

module dcache_ways (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic [dcache_pkg::LINE_WORDS*32-1:0]     fill_line,
    dcache_req_if.ways                               req,
    way_ctrl_if.ways                                 ctrl,
    output logic [dcache_pkg::LINE_WORDS*32-1:0]     line_data
);
    import dcache_pkg::*;

    localparam int PTR_W = $clog2(NUM_WAYS);

    logic [TAG_W-1:0]         tag_arr   [NUM_SETS][NUM_WAYS];
    logic [LINE_WORDS*32-1:0] data_arr  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]      valid_arr [NUM_SETS];
    logic [PTR_W-1:0]         rr_ptr    [NUM_SETS];

    // hit compare and hit-way line select
    always_comb begin
        line_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            ctrl.hit[w] = valid_arr[req.index][w] && (tag_arr[req.index][w] == req.tag);
            if (ctrl.hit[w]) line_data = line_data | data_arr[req.index][w];
        end
    end

    assign ctrl.cache_hit   = |ctrl.hit;
    assign ctrl.lru_way_sel = NUM_WAYS'(1) << rr_ptr[req.index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_arr[s] <= '0;
                rr_ptr[s]    <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (ctrl.tagv_we[w]) valid_arr[req.index][w] <= !ctrl.tagv_clear;
            end
            if (ctrl.fill_en) rr_ptr[req.index] <= rr_ptr[req.index] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ctrl.tagv_we[w] && !ctrl.tagv_clear) begin
                tag_arr[req.index][w] <= req.tag;
            end
            if (ctrl.mem_en[w] && ctrl.way_visit[w]) begin
                for (int b = 0; b < LINE_WORDS*4; b++) begin
                    if (ctrl.mem_we[b]) begin
                        // fill brings the whole line, a store only its lanes
                        data_arr[req.index][w][b*8 +: 8] <= ctrl.fill_en ?
                            fill_line[b*8 +: 8] : req.wdata[(b%4)*8 +: 8];
                    end
                end
            end
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(ctrl.hit));

endmodule

/* sources.f */
dcache_pkg.sv
dcache_if.sv
dcache_req_decode.sv
dcache_main_fsm.sv
dcache_ways.sv
dcache_refill.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    // tests take roughly a thousand cycles
    localparam int MAX_CYCLES = 4000;
    localparam int RANDOM_OPS = 120;

    logic         clk;
    logic         rstn;
    logic         valid;
    mem_op_e      op;
    logic         uncache;
    logic [31:0]  addr;
    access_size_e size;
    logic [31:0]  wdata;
    logic         cacop_en;
    cacop_code_e  cacop_code;
    logic         cache_ready;
    logic         data_valid;
    logic [31:0]  rdata;
    logic         cacop_complete;
    logic         r_req;
    logic [31:0]  r_addr;
    logic [7:0]   r_length;
    logic         r_rdy;
    logic         r_valid;
    logic         r_last;
    logic [31:0]  r_data;
    logic         w_req;
    logic [31:0]  w_addr;
    logic [31:0]  w_data;
    logic [3:0]   w_strb;
    logic         w_rdy;
    logic         w_done;

    logic [7:0]   ref_mem [logic [31:0]];
    int           seed = 32'h5590_bfc6;
    int           errors = 0;
    int           accesses = 0;
    int           cycles = 0;
    int           r_req_cnt = 0;
    int           w_req_cnt = 0;
    logic         r_req_q = 1'b0;
    logic         w_req_q = 1'b0;
    logic [7:0]   last_r_length;
    logic [31:0]  last_r_addr;
    logic [3:0]   last_w_strb;
    logic [31:0]  last_w_addr;

    dcache_top i_dcache_top (.*);

    tb_mem_model i_mem_model (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // bus request counting, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rstn) begin
            r_req_q = 1'b0;
            w_req_q = 1'b0;
        end else begin
            if (r_req && !r_req_q) begin
                r_req_cnt++;
                last_r_length = r_length;
                last_r_addr   = r_addr;
            end
            if (w_req && !w_req_q) begin
                w_req_cnt++;
                last_w_strb = w_strb;
                last_w_addr = w_addr;
            end
            r_req_q = r_req;
            w_req_q = w_req;
        end
    end

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [31:0] base;
        logic [31:0] word;
        base = {a[31:2], 2'b00};
        word = base ^ 32'hA5A5_0000;
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(base + b)) word[b*8 +: 8] = ref_mem[base + b];
        end
        return word;
    endfunction

    // five tags that share set 9
    function automatic logic [31:0] conflict_addr(input int t);
        return 32'h0010_0090 + t * 256;
    endfunction

    task automatic store_ref(input logic [31:0] a, input access_size_e sz,
                             input logic [31:0] wd);
        int nbytes;
        nbytes = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) ref_mem[a + b] = wd[b*8 +: 8];
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Error at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    // n counts falling edges from acceptance to data_valid
    task automatic issue_access(input mem_op_e o, input logic unc, input logic [31:0] a,
                                input access_size_e sz, input logic [31:0] wd,
                                output logic [31:0] rd, output int n);
        @(negedge clk);
        while (!cache_ready) @(negedge clk);
        valid   = 1'b1;
        op      = o;
        uncache = unc;
        addr    = a;
        size    = sz;
        wdata   = wd;
        @(negedge clk);
        valid = 1'b0;
        n = 1;
        while (!data_valid) begin
            @(negedge clk);
            n++;
        end
        rd = rdata;
        accesses++;
    endtask

    task automatic issue_cacop(input cacop_code_e code, input logic [31:0] a, output int n);
        @(negedge clk);
        while (!cache_ready) @(negedge clk);
        cacop_en   = 1'b1;
        cacop_code = code;
        addr       = a;
        @(negedge clk);
        cacop_en = 1'b0;
        n = 1;
        while (!data_valid) begin
            @(negedge clk);
            n++;
        end
        if (!cacop_complete) report_mismatch("cacop_complete with data_valid", 0, 1);
        accesses++;
    endtask

    // a negative new_reqs skips the request count
    task automatic read_and_check(input logic [31:0] a, input logic unc,
                                  input int new_reqs, output int n);
        int rc;
        logic [31:0] rd;
        rc = r_req_cnt;
        issue_access(READ, unc, a, SIZE_WORD, 32'h0, rd, n);
        if (rd !== ref_word(a)) begin
            report_mismatch($sformatf("read data at 0x%08h", a), rd, ref_word(a));
        end
        if (new_reqs >= 0 && r_req_cnt != rc + new_reqs) begin
            report_mismatch($sformatf("r_req count, read 0x%08h", a), r_req_cnt - rc, new_reqs);
        end
    endtask

    task automatic write_and_track(input logic [31:0] a, input access_size_e sz,
                                   input logic [31:0] wd);
        int wc;
        int n;
        logic [31:0] rd;
        wc = w_req_cnt;
        issue_access(WRITE, 1'b0, a, sz, wd, rd, n);
        store_ref(a, sz, wd);
        if (w_req_cnt != wc + 1) begin
            report_mismatch($sformatf("w_req count, write 0x%08h", a), w_req_cnt - wc, 1);
        end
    endtask

    task automatic miss_then_hit();
        int n;
        read_and_check(32'h0000_1234, 1'b0, 1, n);
        if (last_r_length != 8'd3) report_mismatch("line burst r_length", last_r_length, 3);
        if (last_r_addr != 32'h0000_1230) report_mismatch("line r_addr", last_r_addr, 32'h1230);
        read_and_check(32'h0000_1238, 1'b0, 0, n);
        if (n != 1) report_mismatch("read hit latency", n, 1);
    endtask

    task automatic write_hit_and_miss();
        int rc;
        int n;
        rc = r_req_cnt;
        write_and_track(32'h0000_1236, SIZE_BYTE, 32'h0000_005A);
        if (last_w_strb != 4'b0100) report_mismatch("byte write strobe", last_w_strb, 4'b0100);
        if (last_w_addr != 32'h0000_1236) report_mismatch("w_addr", last_w_addr, 32'h1236);
        if (r_req_cnt != rc) report_mismatch("r_req on write hit", r_req_cnt - rc, 0);
        read_and_check(32'h0000_1234, 1'b0, 0, n);
        if (n != 1) report_mismatch("hit latency after write", n, 1);
        // no allocation, so the read still misses
        write_and_track(32'h0000_5540, SIZE_WORD, 32'hC0DE_1234);
        read_and_check(32'h0000_5540, 1'b0, 1, n);
    endtask

    task automatic uncached_reads();
        int n;
        read_and_check(32'h0000_7008, 1'b1, 1, n);
        if (last_r_length != 8'd0) report_mismatch("uncached r_length", last_r_length, 0);
        if (last_r_addr != 32'h0000_7008) report_mismatch("uncached r_addr", last_r_addr, 32'h7008);
        read_and_check(32'h0000_7008, 1'b1, 1, n);
    endtask

    task automatic round_robin_fill();
        int n;
        for (int t = 0; t < 5; t++) read_and_check(conflict_addr(t), 1'b0, 1, n);
        read_and_check(conflict_addr(1), 1'b0, 0, n);
        read_and_check(conflict_addr(0), 1'b0, 1, n);
    endtask

    task automatic invalidation();
        int n;
        issue_cacop(HIT_INVALIDATE, 32'h0000_1234, n);
        if (n != 2) report_mismatch("hit-invalidate latency", n, 2);
        read_and_check(32'h0000_1234, 1'b0, 1, n);
        // set 9 way 2 holds tag 2 by now
        issue_cacop(INDEX_INVALIDATE, 32'h0000_0092, n);
        if (n != 2) report_mismatch("index-invalidate latency", n, 2);
        read_and_check(conflict_addr(3), 1'b0, 0, n);
        read_and_check(conflict_addr(2), 1'b0, 1, n);
    endtask

    task automatic random_traffic();
        int kind;
        int n;
        logic [31:0] a;
        logic [31:0] wd;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            // eight tags over two sets
            a    = 32'h0000_3000 | ({$random(seed)} & 32'h0000_071C);
            kind = {$random(seed)} & 7;
            wd   = $random(seed);
            case (kind)
                0, 1, 2: read_and_check(a, 1'b0, -1, n);
                3:       read_and_check(32'h0000_6000 | (a & 32'hFC), 1'b1, 1, n);
                4:       write_and_track(a + wd[25:24], SIZE_BYTE, wd);
                5:       write_and_track(a + {wd[25], 1'b0}, SIZE_HALF, wd);
                default: write_and_track(a, SIZE_WORD, wd);
            endcase
        end
    endtask

    initial begin
        rstn       = 1'b0;
        valid      = 1'b0;
        op         = READ;
        uncache    = 1'b0;
        addr       = '0;
        size       = SIZE_WORD;
        wdata      = '0;
        cacop_en   = 1'b0;
        cacop_code = INDEX_INVALIDATE;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        if ({cache_ready, r_req, w_req, data_valid, cacop_complete} != 5'b10000) begin
            report_mismatch("outputs after reset",
                {cache_ready, r_req, w_req, data_valid, cacop_complete}, 5'b10000);
        end
        miss_then_hit();
        write_hit_and_miss();
        uncached_reads();
        round_robin_fill();
        invalidation();
        random_traffic();
        $display("Summary: %0d accesses, %0d r_req, %0d w_req, %0d errors",
                 accesses, r_req_cnt, w_req_cnt, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
    input  logic        clk,
    input  logic        rstn,
    input  logic        r_req,
    input  logic [31:0] r_addr,
    input  logic [7:0]  r_length,
    output logic        r_rdy,
    output logic        r_valid,
    output logic        r_last,
    output logic [31:0] r_data,
    input  logic        w_req,
    input  logic [31:0] w_addr,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    output logic        w_rdy,
    output logic        w_done
);
    logic [7:0]  store [logic [31:0]];
    logic [1:0]  rd_phase;
    logic [1:0]  wr_phase;
    logic [31:0] rd_addr;
    logic [7:0]  rd_left;

    // untouched bytes come from the address pattern
    function automatic logic [31:0] load_word(input logic [31:0] a);
        logic [31:0] base;
        logic [31:0] word;
        base = {a[31:2], 2'b00};
        word = base ^ 32'hA5A5_0000;
        for (int b = 0; b < 4; b++) begin
            if (store.exists(base + b)) word[b*8 +: 8] = store[base + b];
        end
        return word;
    endfunction

    initial begin
        r_rdy    = 1'b0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        r_data   = '0;
        w_rdy    = 1'b0;
        w_done   = 1'b0;
        rd_phase = 2'd0;
        wr_phase = 2'd0;
        rd_addr  = '0;
        rd_left  = '0;
    end

    // outputs change on the falling edge only
    always @(negedge clk) begin
        r_rdy   <= 1'b0;
        r_valid <= 1'b0;
        r_last  <= 1'b0;
        w_rdy   <= 1'b0;
        w_done  <= 1'b0;
        if (!rstn) begin
            rd_phase <= 2'd0;
            wr_phase <= 2'd0;
        end else begin
            case (rd_phase)
                2'd0: if (r_req) rd_phase <= 2'd1;
                2'd1: begin
                    r_rdy    <= 1'b1;
                    rd_addr  <= {r_addr[31:2], 2'b00};
                    rd_left  <= r_length;
                    rd_phase <= 2'd2;
                end
                default: begin
                    // beats back to back
                    r_valid <= 1'b1;
                    r_data  <= load_word(rd_addr);
                    r_last  <= (rd_left == 8'd0);
                    rd_addr <= rd_addr + 32'd4;
                    rd_left <= rd_left - 8'd1;
                    if (rd_left == 8'd0) rd_phase <= 2'd0;
                end
            endcase
            case (wr_phase)
                2'd0: if (w_req) wr_phase <= 2'd1;
                2'd1: begin
                    w_rdy <= 1'b1;
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) store[{w_addr[31:2], 2'b00} + b] = w_data[b*8 +: 8];
                    end
                    wr_phase <= 2'd2;
                end
                default: begin
                    w_done   <= 1'b1;
                    wr_phase <= 2'd0;
                end
            endcase
        end
    end

endmodule
